// File: Bender.yml
package:
  name: audio_ac97

sources:
  - common/audio_pkg.sv
  - hw/debounce.sv
  - hw/volume_control.sv
  - hw/ac97/ac97_command_sequencer.sv
  - hw/ac97/ac97_frame_engine.sv
  - hw/ac97/ac97_link.sv
  - hw/audio_top.sv
  - target: test
    files:
      - testbench/audio_assert.sv
      - testbench/audio_checker.sv
      - testbench/tb_audio_top.sv

// File: common/audio_pkg.sv
package audio_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths that carry a meaning
  //////////////////////////////////////////////////////////////////////

  // 0 is quiet, 31 is loud
  typedef logic [4:0]  volume_t;
  // mono pcm sample
  typedef logic [7:0]  sample_t;
  // one ac97 slot
  typedef logic [19:0] slot_t;
  typedef logic [7:0]  cmd_addr_t;
  typedef logic [15:0] cmd_data_t;
  // position in a 256-bit frame
  typedef logic [7:0]  bit_count_t;

  // sixteen states, so the 4-bit encoding wraps by itself
  typedef enum logic [3:0] {
    read_id_a, read_id_b, idle_a, headphone_vol,
    idle_b, pcm_vol, record_select, record_gain,
    idle_c, mic_gain, beep_vol, pcm_bypass,
    idle_d, idle_e, idle_f, idle_g
  } seq_state_t;

  //////////////////////////////////////////////////////////////////////
  // volume, reset delay, debounce
  //////////////////////////////////////////////////////////////////////

  localparam volume_t volume_reset = 5'd8;
  localparam volume_t volume_max = 5'd31;
  localparam int unsigned codec_reset_cycles = 1023;
  // about 10 ms at 27 MHz
  localparam int unsigned debounce_cycles_default = 270000;

  //////////////////////////////////////////////////////////////////////
  // frame layout
  //////////////////////////////////////////////////////////////////////

  localparam bit_count_t frame_last_bit = 8'd255;
  localparam bit_count_t sync_end_bit = 8'd15;
  localparam bit_count_t ready_rise_bit = 8'd128;
  localparam bit_count_t ready_fall_bit = 8'd2;
  // outgoing slot boundaries
  localparam bit_count_t slot1_start_bit = 8'd16;
  localparam bit_count_t slot2_start_bit = 8'd36;
  localparam bit_count_t slot3_start_bit = 8'd56;
  localparam bit_count_t slot4_start_bit = 8'd76;
  // input slots sampled on negedge, one bit later
  localparam bit_count_t capture_left_start_bit = 8'd57;
  localparam bit_count_t capture_right_start_bit = 8'd77;

  //////////////////////////////////////////////////////////////////////
  // codec registers
  //////////////////////////////////////////////////////////////////////

  localparam cmd_addr_t reg_id = 8'h80;
  localparam cmd_addr_t reg_headphone = 8'h04;
  localparam cmd_addr_t reg_pcm = 8'h18;
  localparam cmd_addr_t reg_rec_select = 8'h1A;
  localparam cmd_addr_t reg_rec_gain = 8'h1C;
  localparam cmd_addr_t reg_mic = 8'h0E;
  localparam cmd_addr_t reg_beep = 8'h0A;
  localparam cmd_addr_t reg_general = 8'h20;

  localparam cmd_data_t data_pcm = 16'h0808;
  // record gain at max
  localparam cmd_data_t data_rec_gain = 16'h0F0F;
  // +20 dB mic boost
  localparam cmd_data_t data_mic = 16'h8048;
  localparam cmd_data_t data_beep = 16'h0000;
  // pcm out bypasses mix1
  localparam cmd_data_t data_general = 16'h8000;
  localparam cmd_data_t data_rec_select_mic = 16'h0000;

endpackage

// File: compile.f
common/audio_pkg.sv
hw/debounce.sv
hw/volume_control.sv
hw/ac97/ac97_command_sequencer.sv
hw/ac97/ac97_frame_engine.sv
hw/ac97/ac97_link.sv
hw/audio_top.sv
testbench/audio_assert.sv
testbench/audio_checker.sv
testbench/tb_audio_top.sv

// File: hw/ac97/ac97_command_sequencer.sv
`timescale 1ns/10ps

module ac97_command_sequencer (
  input  logic                 clock_27mhz,
  input  logic                 reset,
  input  logic                 ready,
  input  audio_pkg::volume_t   volume,
  output audio_pkg::cmd_addr_t command_address,
  output audio_pkg::cmd_data_t command_data,
  output logic                 command_valid
);

  import audio_pkg::*;

  seq_state_t state;
  // codec wants attenuation, not gain
  volume_t attenuation;

  assign attenuation = volume_max - volume;

  //////////////////////////////////////////////////////////////////////
  // state walk, one step per frame
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state <= read_id_a;
    end else if (ready) begin
      state <= seq_state_t'(state + 4'd1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // command for the current state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      command_valid <= 1'b0;
    end else begin
      command_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock_27mhz) begin
    case (state)
      headphone_vol: begin
        // same attenuation for left and right fields
        command_address <= reg_headphone;
        command_data <= {3'b000, attenuation, 3'b000, attenuation};
      end
      pcm_vol: begin
        command_address <= reg_pcm;
        command_data <= data_pcm;
      end
      record_select: begin
        // mic on both channels
        command_address <= reg_rec_select;
        command_data <= data_rec_select_mic;
      end
      record_gain: begin
        command_address <= reg_rec_gain;
        command_data <= data_rec_gain;
      end
      mic_gain: begin
        command_address <= reg_mic;
        command_data <= data_mic;
      end
      beep_vol: begin
        command_address <= reg_beep;
        command_data <= data_beep;
      end
      pcm_bypass: begin
        command_address <= reg_general;
        command_data <= data_general;
      end
      default: begin
        // id reads, also filler for the idle states
        command_address <= reg_id;
        command_data <= '0;
      end
    endcase
  end

endmodule

// File: hw/ac97/ac97_frame_engine.sv
`timescale 1ns/10ps

module ac97_frame_engine (
  input  logic                 ac97_bit_clock,
  input  logic                 reset,
  input  audio_pkg::cmd_addr_t command_address,
  input  audio_pkg::cmd_data_t command_data,
  input  logic                 command_valid,
  input  audio_pkg::sample_t   out_sample,
  output logic                 frame_ready,
  output audio_pkg::slot_t     left_in,
  output logic                 ac97_synch,
  output logic                 ac97_sdata_out,
  input  logic                 ac97_sdata_in
);

  import audio_pkg::*;

  localparam int pad_bits = $bits(slot_t) - $bits(sample_t);

  // reset brought over into the bit clock
  logic [1:0] reset_sync;
  logic reset_bit;
  bit_count_t bit_count;

  // words latched at frame end
  slot_t cmd_addr_l;
  slot_t cmd_data_l;
  slot_t sample_slot_l;
  logic cmd_valid_l;
  logic slot_valid_l;

  // msb-first bit of a slot word at frame position pos
  function automatic logic slot_bit(slot_t word, bit_count_t pos, bit_count_t start);
    bit_count_t offset;
    offset = pos - start;
    return word[$bits(slot_t) - 1 - offset];
  endfunction

  always_ff @(posedge ac97_bit_clock) begin
    reset_sync <= {reset_sync[0], reset};
  end

  assign reset_bit = reset_sync[1];

  //////////////////////////////////////////////////////////////////////
  // frame counter, sync, ready level, serializer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (reset_bit) begin
      bit_count <= '0;
      ac97_synch <= 1'b0;
      ac97_sdata_out <= 1'b0;
      frame_ready <= 1'b0;
      // first frame goes out empty
      cmd_valid_l <= 1'b0;
      slot_valid_l <= 1'b0;
    end else begin
      bit_count <= bit_count + 8'd1;

      // sync covers the tag slot
      if (bit_count == frame_last_bit) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == sync_end_bit) begin
        ac97_synch <= 1'b0;
      end

      if (bit_count == ready_rise_bit) begin
        frame_ready <= 1'b1;
      end else if (bit_count == ready_fall_bit) begin
        frame_ready <= 1'b0;
      end

      if (bit_count == frame_last_bit) begin
        cmd_valid_l <= command_valid;
        slot_valid_l <= 1'b1;
      end

      if (bit_count < slot1_start_bit) begin
        // slot 0 tags
        case (bit_count[3:0])
          4'd0:       ac97_sdata_out <= 1'b1;
          4'd1, 4'd2: ac97_sdata_out <= cmd_valid_l;
          4'd3, 4'd4: ac97_sdata_out <= slot_valid_l;
          default:    ac97_sdata_out <= 1'b0;
        endcase
      end else if (bit_count < slot2_start_bit) begin
        ac97_sdata_out <= cmd_valid_l & slot_bit(cmd_addr_l, bit_count, slot1_start_bit);
      end else if (bit_count < slot3_start_bit) begin
        ac97_sdata_out <= cmd_valid_l & slot_bit(cmd_data_l, bit_count, slot2_start_bit);
      end else if (bit_count < slot4_start_bit) begin
        // left playback
        ac97_sdata_out <= slot_valid_l & slot_bit(sample_slot_l, bit_count, slot3_start_bit);
      end else if (bit_count < slot4_start_bit + $bits(slot_t)) begin
        // right playback, same word
        ac97_sdata_out <= slot_valid_l & slot_bit(sample_slot_l, bit_count, slot4_start_bit);
      end else begin
        ac97_sdata_out <= 1'b0;
      end
    end
  end

  // payload for the next frame
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == frame_last_bit) begin
      cmd_addr_l <= {command_address, 12'h000};
      cmd_data_l <= {command_data, 4'h0};
      sample_slot_l <= {out_sample, {pad_bits{1'b0}}};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // left input slot, sampled mid-bit
  //////////////////////////////////////////////////////////////////////

  always_ff @(negedge ac97_bit_clock) begin
    if (reset_bit) begin
      left_in <= '0;
    end else if (bit_count >= capture_left_start_bit &&
                 bit_count < capture_right_start_bit) begin
      left_in <= {left_in[$bits(slot_t)-2:0], ac97_sdata_in};
    end
  end

endmodule

// File: hw/ac97/ac97_link.sv
`timescale 1ns/10ps

module ac97_link (
  input  logic               clock_27mhz,
  input  logic               reset,
  input  audio_pkg::volume_t volume,
  input  audio_pkg::sample_t audio_out_data,
  output audio_pkg::sample_t audio_in_data,
  output logic               ready,
  output logic               audio_reset_b,
  input  logic               ac97_bit_clock,
  input  logic               ac97_sdata_in,
  output logic               ac97_synch,
  output logic               ac97_sdata_out
);

  import audio_pkg::*;

  localparam int reset_count_width = $clog2(codec_reset_cycles + 1);

  logic [reset_count_width-1:0] reset_count;
  // frame_ready crossing into clock_27mhz
  logic [2:0] ready_sync;
  logic frame_ready;
  slot_t left_in;
  sample_t out_sample;
  cmd_addr_t command_address;
  cmd_data_t command_data;
  logic command_valid;

  //////////////////////////////////////////////////////////////////////
  // hold the codec in reset for a while
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      reset_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == reset_count_width'(codec_reset_cycles)) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  // one-cycle pulse on the rising edge
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], frame_ready};
    end
  end

  assign ready = ready_sync[1] & ~ready_sync[2];

  // user sample held for the frame engine
  always_ff @(posedge clock_27mhz) begin
    if (ready) begin
      out_sample <= audio_out_data;
    end
  end

  // capture keeps the top bits of the left slot
  assign audio_in_data = left_in[$bits(slot_t)-1 -: $bits(sample_t)];

  ac97_command_sequencer i_sequencer (
    .clock_27mhz     (clock_27mhz),
    .reset           (reset),
    .ready           (ready),
    .volume          (volume),
    .command_address (command_address),
    .command_data    (command_data),
    .command_valid   (command_valid)
  );

  ac97_frame_engine i_frame_engine (
    .ac97_bit_clock  (ac97_bit_clock),
    .reset           (reset),
    .command_address (command_address),
    .command_data    (command_data),
    .command_valid   (command_valid),
    .out_sample      (out_sample),
    .frame_ready     (frame_ready),
    .left_in         (left_in),
    .ac97_synch      (ac97_synch),
    .ac97_sdata_out  (ac97_sdata_out),
    .ac97_sdata_in   (ac97_sdata_in)
  );

endmodule

// File: hw/audio_top.sv
`timescale 1ns/10ps

module audio_top #(
  parameter int unsigned stable_cycles = audio_pkg::debounce_cycles_default
) (
  input  logic               clock_27mhz,
  input  logic               reset,
  input  logic               button_up,
  input  logic               button_down,
  input  audio_pkg::sample_t audio_out_data,
  output audio_pkg::sample_t audio_in_data,
  output logic               ready,
  output logic               audio_reset_b,
  input  logic               ac97_bit_clock,
  input  logic               ac97_sdata_in,
  output logic               ac97_synch,
  output logic               ac97_sdata_out
);

  import audio_pkg::*;

  // bit 0 up, bit 1 down
  logic [1:0] buttons_raw;
  logic [1:0] buttons_clean;
  volume_t volume;

  assign buttons_raw = {button_down, button_up};

  //////////////////////////////////////////////////////////////////////
  // buttons to volume
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_debounce
    // buttons are active low on the board
    debounce #(
      .stable_cycles (stable_cycles)
    ) i_debounce (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .noisy       (~buttons_raw[i]),
      .clean       (buttons_clean[i])
    );
  end

  volume_control i_volume_control (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .vol_up      (buttons_clean[0]),
    .vol_down    (buttons_clean[1]),
    .volume      (volume)
  );

  ac97_link i_ac97_link (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .volume         (volume),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_bit_clock (ac97_bit_clock),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out)
  );

endmodule

// File: hw/debounce.sv
`timescale 1ns/10ps

module debounce #(
  parameter int unsigned stable_cycles = audio_pkg::debounce_cycles_default
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int count_width = $clog2(stable_cycles + 1);

  logic [count_width-1:0] count;
  // last level seen on the input
  logic last_level;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      last_level <= noisy;
      clean <= noisy;
    end else if (noisy != last_level) begin
      // input moved, start counting again
      last_level <= noisy;
      count <= '0;
    end else if (count == count_width'(stable_cycles)) begin
      // held long enough
      clean <= last_level;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: hw/volume_control.sv
`timescale 1ns/10ps

module volume_control (
  input  logic              clock_27mhz,
  input  logic              reset,
  input  logic              vol_up,
  input  logic              vol_down,
  output audio_pkg::volume_t volume
);

  import audio_pkg::*;

  // levels from the previous cycle
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  assign up_edge = vol_up & ~up_prev;
  assign down_edge = vol_down & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume <= volume_reset;
      // a button held through reset is not a press
      up_prev <= vol_up;
      down_prev <= vol_down;
    end else begin
      up_prev <= vol_up;
      down_prev <= vol_down;
      // saturate at both ends, down wins on a tie
      if (down_edge && volume != '0) begin
        volume <= volume - 1'b1;
      end else if (up_edge && volume != volume_max) begin
        volume <= volume + 1'b1;
      end
    end
  end

endmodule

// File: testbench/audio_assert.sv
`timescale 1ns/10ps

module audio_assert (
  input logic clock_27mhz,
  input logic reset,
  input logic ready,
  input logic frame_ready
);

  // one frame is 256 bit clocks of two system cycles each
  localparam int unsigned frame_cycles = 512;
  localparam int unsigned min_ready_gap = 500;

  // system cycles since the last ready, saturating at a frame
  int unsigned ready_gap;
  int failure_count = 0;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_gap <= frame_cycles;
    end else if (ready) begin
      ready_gap <= 1;
    end else if (ready_gap < frame_cycles) begin
      ready_gap <= ready_gap + 1;
    end
  end

  // at most one ready per frame
  ready_once_per_frame: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    ready |-> ready_gap >= min_ready_gap
  ) else begin
    failure_count++;
    $error("ready pulses closer together than one frame");
  end

  // the pulse lands while the frame engine still holds its level
  ready_inside_frame_ready: assert property (
    @(posedge clock_27mhz) disable iff (reset)
    ready |-> frame_ready
  ) else begin
    failure_count++;
    $error("ready high while frame_ready is low");
  end

endmodule

bind ac97_link audio_assert i_audio_assert (
  .clock_27mhz (clock_27mhz),
  .reset       (reset),
  .ready       (ready),
  .frame_ready (frame_ready)
);

// File: testbench/audio_checker.sv
`timescale 1ns/10ps

module audio_checker (
  input  logic               clock_27mhz,
  input  logic               reset,
  input  logic               ac97_bit_clock,
  input  logic               ac97_synch,
  input  logic               ac97_sdata_out,
  input  logic               ready,
  input  logic               audio_reset_b,
  input  audio_pkg::sample_t audio_in_data,
  input  logic               check_req,
  input  int                 row_index,
  input  audio_pkg::volume_t exp_volume,
  input  audio_pkg::sample_t exp_play,
  input  audio_pkg::sample_t exp_capture,
  output int                 headphone_count,
  output int                 frame_count,
  output int                 check_count,
  output int                 error_count
);

  // one frame as seen on the wire, bit 0 first
  logic [0:255] frame_bits;
  int bit_index;
  int synch_high;
  logic synch_prev;
  logic collecting;
  // latest decoded values
  logic [15:0] last_headphone;
  logic [19:0] last_left;
  logic [19:0] last_right;
  logic [7:0] last_capture;
  // codec reset timing
  int cycles_since_reset;
  logic reset_seen;
  logic codec_released;
  int row_error_base;

  initial begin
    headphone_count = 0;
    frame_count = 0;
    check_count = 0;
    error_count = 0;
    collecting = 1'b0;
    synch_prev = 1'b0;
    bit_index = 0;
    synch_high = 0;
    reset_seen = 1'b0;
    codec_released = 1'b0;
    cycles_since_reset = 0;
    row_error_base = 0;
    last_headphone = 'x;
    last_left = 'x;
    last_right = 'x;
    last_capture = 'x;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // {address, data} sent in each sequencer state
  function automatic logic [23:0] expected_command(input int state);
    case (state)
      3: return {8'h04, 16'h0000};
      5: return {8'h18, 16'h0808};
      6: return {8'h1A, 16'h0000};
      7: return {8'h1C, 16'h0F0F};
      9: return {8'h0E, 16'h8048};
      10: return {8'h0A, 16'h0000};
      11: return {8'h20, 16'h8000};
      default: return {8'h80, 16'h0000};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // frame decode on the bit clock
  //////////////////////////////////////////////////////////////////////

  task automatic check_frame();
    int state;
    logic [23:0] cmd;
    logic [7:0] addr;
    logic [15:0] data;
    // the unframed stretch after reset already used state 0
    state = (frame_count + 1) % 16;
    cmd = expected_command(state);
    addr = frame_bits[16:23];
    data = frame_bits[36:51];
    compare_value("ac97_synch high bits", 16, synch_high);
    compare_value("slot 0 tags", 5'b11111, frame_bits[0:4]);
    compare_value("command address", cmd[23:16], addr);
    if (state == 3) begin
      // volume dependent, checked against the table row
      last_headphone = data;
      headphone_count++;
    end else begin
      compare_value("command data", cmd[15:0], data);
    end
    last_left = frame_bits[56:75];
    last_right = frame_bits[76:95];
    frame_count++;
  endtask

  always @(negedge ac97_bit_clock) begin
    if (ac97_synch === 1'b1 && synch_prev !== 1'b1) begin
      // the rise lines up with the last bit of the old frame
      if (collecting) begin
        frame_bits[255] = ac97_sdata_out;
        check_frame();
      end
      collecting = 1'b1;
      bit_index = 0;
      synch_high = 1;
    end else if (collecting) begin
      if (ac97_synch === 1'b1) begin
        synch_high++;
      end
      if (bit_index < 255) begin
        frame_bits[bit_index] = ac97_sdata_out;
      end
      bit_index++;
    end
    synch_prev = ac97_synch;
  end

  //////////////////////////////////////////////////////////////////////
  // reset delay, capture, row results
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock_27mhz) begin
    if (reset === 1'b1) begin
      cycles_since_reset = 0;
      reset_seen = 1'b1;
    end else if (reset_seen && !codec_released) begin
      if (audio_reset_b === 1'b1) begin
        codec_released = 1'b1;
        compare_value("audio_reset_b release cycle", 1024, cycles_since_reset);
        $display("codec reset: released after %0d cycles", cycles_since_reset);
      end else if (audio_reset_b !== 1'b0) begin
        error_count++;
        $display("audio_reset_b is not low while the codec is held in reset");
      end
      cycles_since_reset++;
    end else if (codec_released && audio_reset_b !== 1'b1) begin
      error_count++;
      $display("audio_reset_b fell after the codec was released");
    end

    // capture valid at the ready cycle
    if (ready === 1'b1) begin
      last_capture = audio_in_data;
    end

    if (check_req === 1'b1) begin
      // attenuation in both channel fields
      compare_value("headphone left field", 31 - exp_volume, last_headphone[12:8]);
      compare_value("headphone right field", 31 - exp_volume, last_headphone[4:0]);
      compare_value("headphone unused bits", 0,
                    {last_headphone[15:13], last_headphone[7:5]});
      compare_value("slot 3 word", {exp_play, 12'h000}, last_left);
      compare_value("slot 4 word", {exp_play, 12'h000}, last_right);
      compare_value("audio_in_data", exp_capture, last_capture);
      if (error_count == row_error_base) begin
        $display("row %0d: volume %0d, ok", row_index, exp_volume);
      end else begin
        $display("row %0d: volume %0d, %0d errors", row_index, exp_volume,
                 error_count - row_error_base);
      end
      row_error_base = error_count;
    end
  end

endmodule

// File: testbench/tb_audio_top.sv
`timescale 1ns/10ps

module tb_audio_top;

  import audio_pkg::*;

  localparam int row_total = 7;
  localparam int hold_cycles = 24;
  localparam int release_timeout = 3000;
  // two headphone passes take at most 32 frames of 512 cycles
  localparam int frame_timeout = 40000;
  localparam int action_none = 0;
  localparam int action_up = 1;
  localparam int action_down = 2;

  logic clock_27mhz;
  logic reset;
  logic button_up;
  logic button_down;
  sample_t audio_out_data;
  sample_t audio_in_data;
  logic ready;
  logic audio_reset_b;
  logic ac97_bit_clock;
  logic ac97_sdata_in;
  logic ac97_synch;
  logic ac97_sdata_out;

  // checker handshake
  logic check_req;
  int row_index;
  volume_t exp_volume;
  sample_t exp_play;
  sample_t exp_capture;
  int headphone_count;
  int frame_count;
  int check_count;
  int error_count;
  // checker errors plus assertion failures
  int total_errors;

  // stimulus table
  int row_action [row_total];
  int row_repeat [row_total];
  sample_t row_play [row_total];
  sample_t row_capture [row_total];
  volume_t row_volume [row_total];

  logic [15:0] lfsr_state;
  logic timed_out;
  // codec model
  sample_t capture_sample;
  int codec_pos;
  logic codec_synch_prev;

  audio_top #(
    .stable_cycles (16)
  ) i_dut (
    .clock_27mhz    (clock_27mhz),
    .reset          (reset),
    .button_up      (button_up),
    .button_down    (button_down),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_bit_clock (ac97_bit_clock),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out)
  );

  audio_checker i_checker (
    .clock_27mhz     (clock_27mhz),
    .reset           (reset),
    .ac97_bit_clock  (ac97_bit_clock),
    .ac97_synch      (ac97_synch),
    .ac97_sdata_out  (ac97_sdata_out),
    .ready           (ready),
    .audio_reset_b   (audio_reset_b),
    .audio_in_data   (audio_in_data),
    .check_req       (check_req),
    .row_index       (row_index),
    .exp_volume      (exp_volume),
    .exp_play        (exp_play),
    .exp_capture     (exp_capture),
    .headphone_count (headphone_count),
    .frame_count     (frame_count),
    .check_count     (check_count),
    .error_count     (error_count)
  );

  //////////////////////////////////////////////////////////////////////
  // clocks and codec model
  //////////////////////////////////////////////////////////////////////

  always #20 clock_27mhz = ~clock_27mhz;

  // 80 ns bit clock, edges away from the system posedges
  always #40 ac97_bit_clock = ~ac97_bit_clock;

  // codec drives the left slot msb first, position taken from sync
  always @(posedge ac97_bit_clock) begin
    if (ac97_synch === 1'b1 && codec_synch_prev !== 1'b1) begin
      codec_pos = 0;
    end else begin
      codec_pos = codec_pos + 1;
    end
    codec_synch_prev = ac97_synch;
    if (codec_pos >= 56 && codec_pos <= 75) begin
      ac97_sdata_in <= (codec_pos < 64) ? capture_sample[63 - codec_pos] :
                       codec_pos[0];
    end else begin
      ac97_sdata_in <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // table setup
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic sample_t random_sample();
    sample_t value;
    for (int i = 0; i < 8; i++) begin
      value[i] = lfsr_bit();
    end
    return value;
  endfunction

  // saturating volume step, 0 to 31
  function automatic volume_t next_volume(input volume_t volume, input int action);
    if (action == action_up && volume != 5'd31) begin
      return volume + 5'd1;
    end else if (action == action_down && volume != 5'd0) begin
      return volume - 5'd1;
    end
    return volume;
  endfunction

  task automatic set_row(input int row, input int action, input int count);
    volume_t volume;
    volume = (row == 0) ? 5'd8 : row_volume[row - 1];
    for (int i = 0; i < count; i++) begin
      volume = next_volume(volume, action);
    end
    row_action[row] = action;
    row_repeat[row] = count;
    row_play[row] = random_sample();
    row_capture[row] = random_sample();
    row_volume[row] = volume;
  endtask

  //////////////////////////////////////////////////////////////////////
  // driving
  //////////////////////////////////////////////////////////////////////

  task automatic press_button(input int action);
    if (action == action_up) begin
      button_up <= 1'b0;
    end else begin
      button_down <= 1'b0;
    end
    repeat (hold_cycles) @(posedge clock_27mhz);
    button_up <= 1'b1;
    button_down <= 1'b1;
    repeat (hold_cycles) @(posedge clock_27mhz);
  endtask

  task automatic wait_codec_release();
    int cycles;
    cycles = 0;
    while (audio_reset_b !== 1'b1 && cycles < release_timeout) begin
      @(posedge clock_27mhz);
      cycles++;
    end
    if (audio_reset_b !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout: codec reset was never released");
    end
  endtask

  task automatic wait_headphone_frames(input int frames_needed);
    int first;
    int cycles;
    first = headphone_count;
    cycles = 0;
    while (headphone_count < first + frames_needed && cycles < frame_timeout) begin
      @(posedge clock_27mhz);
      cycles++;
    end
    if (headphone_count < first + frames_needed) begin
      timed_out = 1'b1;
      $display("timeout: no headphone command frame within %0d cycles", frame_timeout);
    end
  endtask

  task automatic run_row(input int row);
    audio_out_data <= row_play[row];
    capture_sample <= row_capture[row];
    for (int i = 0; i < row_repeat[row]; i++) begin
      press_button(row_action[row]);
    end
    // the first headphone frame may still carry the old volume
    wait_headphone_frames(2);
    if (!timed_out) begin
      row_index <= row;
      exp_volume <= row_volume[row];
      exp_play <= row_play[row];
      exp_capture <= row_capture[row];
      check_req <= 1'b1;
      @(posedge clock_27mhz);
      check_req <= 1'b0;
      @(posedge clock_27mhz);
    end
  endtask

  initial begin
    clock_27mhz = 1'b0;
    ac97_bit_clock = 1'b0;
    reset = 1'b1;
    button_up = 1'b1;
    button_down = 1'b1;
    audio_out_data = '0;
    ac97_sdata_in = 1'b0;
    check_req = 1'b0;
    row_index = 0;
    exp_volume = '0;
    exp_play = '0;
    exp_capture = '0;
    capture_sample = '0;
    codec_pos = 300;
    codec_synch_prev = 1'b0;
    timed_out = 1'b0;
    total_errors = 0;
    lfsr_state = 16'd8224;

    set_row(0, action_none, 0);
    set_row(1, action_up, 3);
    set_row(2, action_up, 25);
    set_row(3, action_down, 2);
    set_row(4, action_down, 35);
    set_row(5, action_up, 1);
    set_row(6, action_none, 0);

    repeat (2) @(posedge clock_27mhz);
    reset <= 1'b0;
    wait_codec_release();
    for (int r = 0; r < row_total && !timed_out; r++) begin
      run_row(r);
    end
    repeat (4) @(posedge clock_27mhz);

    total_errors = error_count + i_dut.i_ac97_link.i_audio_assert.failure_count;
    $display("frames %0d, checks %0d, errors %0d", frame_count, check_count, total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
